// File: vaddrgen_stimulus.txt
# op vew addr vl stride hold err len size, all hex
# op 0 VLE 1 VSE 2 VLSE 3 VSSE, vew log2 bytes, hold is store-pending cycles
0 2 00001000 0010 00000000 0 0 07 3
0 0 00002008 0021 00000000 0 0 04 3
1 1 00003002 0008 00000000 0 0 07 1
1 2 00003004 0005 00000000 0 0 04 2
1 0 00004003 000a 00000000 0 0 09 0
1 3 00005000 0004 00000000 6 0 03 3
2 2 00006000 0005 00000010 0 0 00 2
2 1 00007100 0004 fffffffa 0 0 00 1
3 3 00008000 0006 00000040 4 0 00 3
0 1 00009001 0004 00000000 0 1 00 0
3 2 0000a002 0003 00000008 0 1 00 0
0 3 0000b000 0008 00000000 a 0 07 3
1 2 0000c000 0002 00000000 0 0 00 3
2 0 0000d005 0006 00000003 0 0 00 0
3 1 0000e000 0003 00000100 0 0 00 1
0 0 0000f000 0100 00000000 0 0 1f 3
1 3 00010000 0020 00000000 3 0 1f 3
2 3 00011000 0003 ffffffc0 0 0 00 3

// File: all.f
vaddr_axi_pkg.sv
vaddr_insn_pkg.sv
addr_req_if.sv
lsu_queue_if.sv
vaddr_insn_ctrl.sv
vaddr_axi_reqgen.sv
lsu_req_fifo.sv
vaddrgen.sv
tb_vaddrgen.sv

// File: Makefile
# Verilator flow for the vector memory address generator

VERILATOR  ?= verilator
TB_TOP     ?= tb_vaddrgen
RTL_TOP    ?= vaddrgen
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result is taken from the log, not from the exit status
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_vaddrgen.sv
// Testbench for the vector memory address generator
// Replays the stimulus file and checks AR/AW beats, queue entries and acks

`timescale 1ns/1ps

module tb_vaddrgen
  import vaddr_axi_pkg::*;
  import vaddr_insn_pkg::*;
();

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  mem_op_e    req_op_i;
  axi_addr_t  req_addr_i;
  vlen_t      req_vl_i;
  stride_t    req_stride_i;
  vew_e       req_vew_i;
  logic       ack_o;
  logic       error_o;
  logic       core_st_pending_i;
  axi_addr_t  ar_addr_o;
  axi_len_t   ar_len_o;
  axi_size_t  ar_size_o;
  axi_burst_t ar_burst_o;
  axi_cache_t ar_cache_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  axi_addr_t  aw_addr_o;
  axi_len_t   aw_len_o;
  axi_size_t  aw_size_o;
  axi_burst_t aw_burst_o;
  axi_cache_t aw_cache_o;
  logic       aw_valid_o;
  logic       aw_ready_i;
  axi_addr_t  lsu_req_addr_o;
  axi_len_t   lsu_req_len_o;
  axi_size_t  lsu_req_size_o;
  logic       lsu_req_is_load_o;
  logic       lsu_req_valid_o;
  logic       lsu_req_ready_i;

  // Stimulus table, one entry per file line
  mem_op_e    s_op[$];
  vew_e       s_vew[$];
  axi_addr_t  s_addr[$];
  vlen_t      s_vl[$];
  stride_t    s_stride[$];
  int         s_hold[$];
  logic       s_err[$];
  axi_len_t   s_len[$];
  axi_size_t  s_size[$];

  // Expected beats in issue order, with the instruction they belong to
  lsu_req_t   exp_ax[$];
  int         exp_ax_id[$];
  lsu_req_t   exp_lsu[$];
  int         exp_lsu_id[$];

  integer     seed        = 32'h0248_148d;
  int         cycle_cnt   = 0;
  int         cycle_limit = 16;
  int         fd;
  string      line;
  int         f_op, f_vew, f_hold, f_err, f_len, f_size;
  logic [31:0] f_addr, f_vl, f_stride;

  vaddrgen i_dut (.*);

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_addr(string name, axi_addr_t exp, axi_addr_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_len(string name, axi_len_t exp, axi_len_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_size(string name, axi_size_t exp, axi_size_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_burst(string name, axi_burst_t exp, axi_burst_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_cache(string name, axi_cache_t exp, axi_cache_t act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) fail_stop($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  // One AR or AW transfer against the head of the expected stream
  task automatic check_beat(string chan, logic is_load, axi_addr_t addr, axi_len_t len,
                            axi_size_t size, axi_burst_t burst, axi_cache_t cache);
    lsu_req_t e;
    string    name;
    if (exp_ax.size() == 0) begin
      fail_stop($sformatf("Unexpected %s request at address %h", chan, addr));
    end else begin
      e    = exp_ax.pop_front();
      name = $sformatf("insn%0d %s", exp_ax_id.pop_front(), chan);
      check_flag({name, " direction"}, e.is_load, is_load);
      check_addr({name, " addr"}, e.addr, addr);
      check_len({name, " len"}, e.len, len);
      check_size({name, " size"}, e.size, size);
      // AXI INCR burst and normal non-cacheable modifiable memory
      check_burst({name, " burst"}, 2'b01, burst);
      check_cache({name, " cache"}, 4'b0010, cache);
    end
  endtask

  ////////////////////////////////////////
  // Monitors sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && aw_valid_o) fail_stop("AR and AW requests valid in the same cycle");
      if (aw_valid_o && core_st_pending_i) fail_stop("AW request while a scalar store is pending");
      // Direction ordering against the queue head
      if (aw_valid_o && lsu_req_valid_o && lsu_req_is_load_o)
        fail_stop("AW request while a load entry heads the queue");
      if (ar_valid_o && lsu_req_valid_o && !lsu_req_is_load_o)
        fail_stop("AR request while a store entry heads the queue");
      if (ar_valid_o && ar_ready_i)
        check_beat("ar", 1'b1, ar_addr_o, ar_len_o, ar_size_o, ar_burst_o, ar_cache_o);
      if (aw_valid_o && aw_ready_i)
        check_beat("aw", 1'b0, aw_addr_o, aw_len_o, aw_size_o, aw_burst_o, aw_cache_o);
    end
  end

  // LSU queue output follows the same stream
  always @(negedge clk_i) begin
    lsu_req_t e;
    string    name;
    if (rst_ni && lsu_req_valid_o && lsu_req_ready_i) begin
      if (exp_lsu.size() == 0) begin
        fail_stop($sformatf("Unexpected LSU entry at address %h", lsu_req_addr_o));
      end else begin
        e    = exp_lsu.pop_front();
        name = $sformatf("insn%0d lsu", exp_lsu_id.pop_front());
        check_addr({name, " addr"}, e.addr, lsu_req_addr_o);
        check_len({name, " len"}, e.len, lsu_req_len_o);
        check_size({name, " size"}, e.size, lsu_req_size_o);
        check_flag({name, " is_load"}, e.is_load, lsu_req_is_load_o);
      end
    end
  end

  // Random back-pressure on all ready inputs
  always @(posedge clk_i) begin
    if (rst_ni) begin
      ar_ready_i      <= ($random(seed) & 3) != 0;
      aw_ready_i      <= ($random(seed) & 3) != 0;
      lsu_req_ready_i <= ($random(seed) & 1) != 0;
    end
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
      fail_stop($sformatf("Simulation hang, no completion within %0d cycles", cycle_limit));
  end

  ////////////////////////////////////////
  // Instruction driver
  ////////////////////////////////////////

  task automatic run_insn(int idx);
    lsu_req_t e;
    string    name;
    logic     is_load;
    logic     acked;
    int       waited;
    name    = $sformatf("insn%0d", idx);
    is_load = s_op[idx] inside {VLE, VLSE};
    // Expected stream with one beat per burst and one per strided element
    if (!s_err[idx]) begin
      for (int k = 0; k < ((s_op[idx] inside {VLE, VSE}) ? 1 : int'(s_vl[idx])); k++) begin
        e.addr    = s_addr[idx] + axi_addr_t'(k) * axi_addr_t'(s_stride[idx]);
        e.len     = s_len[idx];
        e.size    = s_size[idx];
        e.is_load = is_load;
        exp_ax.push_back(e);
        exp_ax_id.push_back(idx);
        exp_lsu.push_back(e);
        exp_lsu_id.push_back(idx);
      end
    end
    @(posedge clk_i);
    core_st_pending_i <= (s_hold[idx] != 0);
    req_valid_i       <= 1'b1;
    req_op_i          <= s_op[idx];
    req_addr_i        <= s_addr[idx];
    req_vl_i          <= s_vl[idx];
    req_stride_i      <= s_stride[idx];
    req_vew_i         <= s_vew[idx];
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    acked  = 1'b0;
    waited = 1;
    while (!acked) begin
      @(negedge clk_i);
      if (ack_o) begin
        acked = 1'b1;
        check_flag({name, " error"}, s_err[idx], error_o);
      end
      @(posedge clk_i);
      waited++;
      // Pending stays high through a load, which must not be held back
      if (!is_load && waited >= s_hold[idx]) core_st_pending_i <= 1'b0;
    end
    if (exp_ax.size() != 0) fail_stop({name, " acknowledged before all requests were issued"});
    core_st_pending_i <= 1'b0;
  endtask

  initial begin
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_op_i          = VLE;
    req_addr_i        = '0;
    req_vl_i          = '0;
    req_stride_i      = '0;
    req_vew_i         = EW8;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    lsu_req_ready_i   = 1'b0;

    fd = $fopen("vaddrgen_stimulus.txt", "r");
    if (fd == 0) fail_stop("Cannot open the stimulus file vaddrgen_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_vew, f_addr, f_vl,
                    f_stride, f_hold, f_err, f_len, f_size) == 9) begin
          s_op.push_back(mem_op_e'(f_op));
          s_vew.push_back(vew_e'(f_vew));
          s_addr.push_back(f_addr);
          s_vl.push_back(vlen_t'(f_vl));
          s_stride.push_back(f_stride);
          s_hold.push_back(f_hold);
          s_err.push_back(f_err != 0);
          s_len.push_back(axi_len_t'(f_len));
          s_size.push_back(axi_size_t'(f_size));
        end
      end
    end
    $fclose(fd);
    if (s_op.size() == 0) fail_stop("The stimulus file holds no instruction");
    cycle_limit = 16 + 300 * s_op.size();

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("reset ack", 1'b0, ack_o);
    check_flag("reset error", 1'b0, error_o);
    check_flag("reset ar_valid", 1'b0, ar_valid_o);
    check_flag("reset aw_valid", 1'b0, aw_valid_o);
    check_flag("reset lsu_valid", 1'b0, lsu_req_valid_o);

    for (int i = 0; i < s_op.size(); i++) begin
      run_insn(i);
    end
    // Let the queue drain toward the load/store units
    while (exp_lsu.size() != 0) @(posedge clk_i);
    @(posedge clk_i);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: vaddrgen.sv
// Vector memory address generator top level
// Instruction controller, AXI request generator and load/store queue on plain ports

`timescale 1ns/1ps

module vaddrgen
  import vaddr_axi_pkg::*;
  import vaddr_insn_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction side
  input  logic       req_valid_i,
  input  mem_op_e    req_op_i,
  input  axi_addr_t  req_addr_i,
  input  vlen_t      req_vl_i,
  input  stride_t    req_stride_i,
  input  vew_e       req_vew_i,
  output logic       ack_o,
  output logic       error_o,
  input  logic       core_st_pending_i,
  // AR channel
  output axi_addr_t  ar_addr_o,
  output axi_len_t   ar_len_o,
  output axi_size_t  ar_size_o,
  output axi_burst_t ar_burst_o,
  output axi_cache_t ar_cache_o,
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  // AW channel
  output axi_addr_t  aw_addr_o,
  output axi_len_t   aw_len_o,
  output axi_size_t  aw_size_o,
  output axi_burst_t aw_burst_o,
  output axi_cache_t aw_cache_o,
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  // Load/store unit queue
  output axi_addr_t  lsu_req_addr_o,
  output axi_len_t   lsu_req_len_o,
  output axi_size_t  lsu_req_size_o,
  output logic       lsu_req_is_load_o,
  output logic       lsu_req_valid_o,
  input  logic       lsu_req_ready_i
);

  addr_req_if  areq_if ();
  lsu_queue_if lsuq_if ();

  lsu_req_t lsu_req;

  // Queue head split into separate fields
  assign lsu_req_addr_o    = lsu_req.addr;
  assign lsu_req_len_o     = lsu_req.len;
  assign lsu_req_size_o    = lsu_req.size;
  assign lsu_req_is_load_o = lsu_req.is_load;

  vaddr_insn_ctrl i_insn_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_vl_i     (req_vl_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .ack_o        (ack_o),
    .error_o      (error_o),
    .areq         (areq_if.ctrl)
  );

  vaddr_axi_reqgen i_axi_reqgen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .core_st_pending_i (core_st_pending_i),
    .areq              (areq_if.gen),
    .lsuq              (lsuq_if.gen),
    .ar_addr_o         (ar_addr_o),
    .ar_len_o          (ar_len_o),
    .ar_size_o         (ar_size_o),
    .ar_burst_o        (ar_burst_o),
    .ar_cache_o        (ar_cache_o),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .aw_addr_o         (aw_addr_o),
    .aw_len_o          (aw_len_o),
    .aw_size_o         (aw_size_o),
    .aw_burst_o        (aw_burst_o),
    .aw_cache_o        (aw_cache_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i)
  );

  lsu_req_fifo #(
    .Depth (LsuQueueDepth)
  ) i_lsu_fifo (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsuq            (lsuq_if.fifo),
    .lsu_req_o       (lsu_req),
    .lsu_req_valid_o (lsu_req_valid_o),
    .lsu_req_ready_i (lsu_req_ready_i)
  );

endmodule

// File: lsu_req_fifo.sv
// Load/store request queue
// Circular buffer of issued AXI requests toward the load/store units

`timescale 1ns/1ps

module lsu_req_fifo
  import vaddr_axi_pkg::*;
#(
  parameter int unsigned Depth = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  lsu_queue_if.fifo  lsuq,
  // Toward the load/store units
  output lsu_req_t   lsu_req_o,
  output logic       lsu_req_valid_o,
  input  logic       lsu_req_ready_i
);

  // Storage, written on push only
  lsu_req_t mem_q [Depth];

  logic [$clog2(Depth)-1:0] wr_ptr_q;
  logic [$clog2(Depth)-1:0] rd_ptr_q;
  logic [$clog2(Depth):0]   count_q;
  logic                     pop;

  assign lsuq.empty        = (count_q == '0);
  assign lsuq.full         = (count_q == Depth);
  assign lsuq.head_is_load = mem_q[rd_ptr_q].is_load;

  // Head of queue, valid one cycle after its push
  assign lsu_req_o       = mem_q[rd_ptr_q];
  assign lsu_req_valid_o = !lsuq.empty;
  assign pop             = lsu_req_valid_o && lsu_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (lsuq.push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (lsuq.push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !lsuq.push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsuq.push) mem_q[wr_ptr_q] <= lsuq.entry;
  end

endmodule

// File: vaddr_axi_reqgen.sv
// AXI request generator for vector loads and stores
// Emits AR/AW beats and matching queue entries, with store narrowing and ordering

`timescale 1ns/1ps

module vaddr_axi_reqgen
  import vaddr_axi_pkg::*;
  import vaddr_insn_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Scalar core still has a store in flight
  input  logic        core_st_pending_i,
  addr_req_if.gen     areq,
  lsu_queue_if.gen    lsuq,
  // AR channel
  output axi_addr_t   ar_addr_o,
  output axi_len_t    ar_len_o,
  output axi_size_t   ar_size_o,
  output axi_burst_t  ar_burst_o,
  output axi_cache_t  ar_cache_o,
  output logic        ar_valid_o,
  input  logic        ar_ready_i,
  // AW channel
  output axi_addr_t   aw_addr_o,
  output axi_len_t    aw_len_o,
  output axi_size_t   aw_size_o,
  output axi_burst_t  aw_burst_o,
  output axi_cache_t  aw_cache_o,
  output logic        aw_valid_o,
  input  logic        aw_ready_i
);

  // Position of the lowest set bit, full bus size when none is set
  function automatic axi_size_t trailing_zeros(logic [AxiOffsetWidth-1:0] bits);
    axi_size_t cnt;
    cnt = axi_size_t'(AxiOffsetWidth);
    for (int i = AxiOffsetWidth - 1; i >= 0; i--) begin
      if (bits[i]) cnt = axi_size_t'(i);
    end
    return cnt;
  endfunction

  typedef enum logic [1:0] {IDLE, WAITING, REQUESTING} gen_state_e;

  gen_state_e state_q, state_d;

  // Working copy of the request
  axi_addr_t  addr_q;
  vlen_t      cnt_q;       // elements left, strided only
  stride_t    stride_q;
  vew_e       vew_q;
  logic       is_load_q;
  logic       is_burst_q;
  axi_size_t  eff_size_q;  // beat size for bursts

  axi_addr_t  burst_bytes;
  axi_len_t   beat_len;
  axi_size_t  beat_size;
  logic       order_ok;
  logic       beat_valid;
  logic       ax_ready;
  logic       beat_fire;
  logic       last_beat;

  ////////////////////////////////////////
  // Beat formation
  ////////////////////////////////////////

  // Total bytes of a unit-stride access
  assign burst_bytes = axi_addr_t'(cnt_q) << vew_q;

  // Burst: one beat over the whole range; strided: one element per beat
  assign beat_len  = is_burst_q ? axi_len_t'((burst_bytes - 1'b1) >> eff_size_q) : '0;
  assign beat_size = is_burst_q ? eff_size_q : axi_size_t'(vew_q);

  // No direction change while the other direction is still queued
  assign order_ok   = lsuq.empty || (lsuq.head_is_load == is_load_q);
  assign beat_valid = (state_q == REQUESTING) && order_ok && !lsuq.full;
  assign ax_ready   = is_load_q ? ar_ready_i : aw_ready_i;
  assign beat_fire  = beat_valid && ax_ready;
  // Treats a zero length like a single element
  assign last_beat  = is_burst_q || (cnt_q <= vlen_t'(1));

  assign ar_valid_o = beat_valid && is_load_q;
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = beat_len;
  assign ar_size_o  = beat_size;
  assign ar_burst_o = BurstIncr;
  assign ar_cache_o = CacheModifiable;

  assign aw_valid_o = beat_valid && !is_load_q;
  assign aw_addr_o  = addr_q;
  assign aw_len_o   = beat_len;
  assign aw_size_o  = beat_size;
  assign aw_burst_o = BurstIncr;
  assign aw_cache_o = CacheModifiable;

  // Queue entry goes in together with the AXI transfer
  assign lsuq.push  = beat_fire;
  assign lsuq.entry = '{addr: addr_q, len: beat_len, size: beat_size, is_load: is_load_q};

  assign areq.ready = beat_fire && last_beat;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (areq.valid) begin
          // Stores wait for the scalar core to drain
          state_d = (!areq.is_load && core_st_pending_i) ? WAITING : REQUESTING;
        end
      end
      WAITING: begin
        if (!core_st_pending_i) state_d = REQUESTING;
      end
      REQUESTING: begin
        if (beat_fire && last_beat) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture and strided advance
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && areq.valid) begin
      addr_q     <= areq.addr;
      cnt_q      <= areq.len;
      stride_q   <= areq.stride;
      vew_q      <= areq.vew;
      is_load_q  <= areq.is_load;
      is_burst_q <= areq.is_burst;
      // Store off the bus word boundary gets a narrower beat
      if (!areq.is_load && (areq.addr[AxiOffsetWidth-1:0] != '0)) begin
        eff_size_q <= trailing_zeros(areq.addr[AxiOffsetWidth-1:0]);
      end else begin
        eff_size_q <= axi_size_t'(AxiOffsetWidth);
      end
    end else if (beat_fire && !is_burst_q) begin
      addr_q <= addr_q + axi_addr_t'(stride_q);
      cnt_q  <= cnt_q - 1'b1;
    end
  end

endmodule

// File: vaddr_insn_ctrl.sv
// Vector memory instruction controller
// Registers one instruction, checks element alignment and acknowledges it

`timescale 1ns/1ps

module vaddr_insn_ctrl
  import vaddr_axi_pkg::*;
  import vaddr_insn_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Instruction side
  input  logic         req_valid_i,
  input  mem_op_e      req_op_i,
  input  axi_addr_t    req_addr_i,
  input  vlen_t        req_vl_i,
  input  stride_t      req_stride_i,
  input  vew_e         req_vew_i,
  output logic         ack_o,
  output logic         error_o,
  // Toward the request generator
  addr_req_if.ctrl     areq
);

  // Base address must be a multiple of the element size
  function automatic logic addr_misaligned(axi_addr_t addr, vew_e vew);
    logic [AxiOffsetWidth-1:0] mask;
    mask = AxiOffsetWidth'((1 << vew) - 1);
    return |(addr[AxiOffsetWidth-1:0] & mask);
  endfunction

  typedef enum logic [1:0] {IDLE, CHECK, ISSUE} ctrl_state_e;

  ctrl_state_e state_q, state_d;

  // Captured instruction
  mem_op_e   op_q;
  axi_addr_t addr_q;
  vlen_t     vl_q;
  stride_t   stride_q;
  vew_e      vew_q;

  logic      misaligned;

  assign misaligned = addr_misaligned(addr_q, vew_q);

  // Request payload straight from the captured instruction
  assign areq.addr     = addr_q;
  assign areq.len      = vl_q;
  assign areq.stride   = stride_q;
  assign areq.vew      = vew_q;
  assign areq.is_load  = is_load_op(op_q);
  assign areq.is_burst = is_unit_stride(op_q);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    areq.valid = 1'b0;
    ack_o      = 1'b0;
    error_o    = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_valid_i) state_d = CHECK;
      end
      CHECK: begin
        // Misaligned: error ack, nothing reaches the bus
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = IDLE;
        end else begin
          areq.valid = 1'b1;
          state_d    = ISSUE;
        end
      end
      ISSUE: begin
        // Hold until the last beat has gone out
        areq.valid = 1'b1;
        if (areq.ready) begin
          ack_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction capture, only while idle
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      op_q     <= req_op_i;
      addr_q   <= req_addr_i;
      vl_q     <= req_vl_i;
      stride_q <= req_stride_i;
      vew_q    <= req_vew_i;
    end
  end

endmodule

// File: lsu_queue_if.sv
// Push side of the load/store request queue
// Generator pushes entries, the queue reports its fill state and head direction

`timescale 1ns/1ps

interface lsu_queue_if
  import vaddr_axi_pkg::*;
();

  // Write port
  logic     push;
  lsu_req_t entry;

  // Queue status
  logic     full;
  logic     empty;
  // Direction of the oldest entry, only meaningful when not empty
  logic     head_is_load;

  // Request generator side
  modport gen (
    output push, entry,
    input  full, empty, head_is_load
  );

  // Queue side
  modport fifo (
    input  push, entry,
    output full, empty, head_is_load
  );

endinterface

// File: addr_req_if.sv
// Request channel from the instruction controller to the AXI request generator
// Payload holds while valid is high, ready pulses on the last beat

`timescale 1ns/1ps

interface addr_req_if
  import vaddr_axi_pkg::*;
  import vaddr_insn_pkg::*;
();

  // Request payload
  axi_addr_t addr;
  vlen_t     len;
  stride_t   stride;
  vew_e      vew;
  logic      is_load;
  logic      is_burst;

  // Handshake
  logic      valid;
  logic      ready;

  // Instruction controller side
  modport ctrl (
    output addr, len, stride, vew, is_load, is_burst, valid,
    input  ready
  );

  // Request generator side
  modport gen (
    input  addr, len, stride, vew, is_load, is_burst, valid,
    output ready
  );

endinterface

// File: vaddr_insn_pkg.sv
// Vector memory instruction package
// Operation and element width encodings, length and stride types

package vaddr_insn_pkg;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Width of the vector length field
  localparam int unsigned VlWidth       = 16;
  // Width of the byte stride
  localparam int unsigned StrideWidth   = 32;
  // Entries in the queue toward the load/store units
  localparam int unsigned LsuQueueDepth = 4;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Supported memory operations
  typedef enum logic [1:0] {
    VLE,   // unit-stride load
    VSE,   // unit-stride store
    VLSE,  // strided load
    VSSE   // strided store
  } mem_op_e;

  typedef logic [VlWidth-1:0]            vlen_t;
  typedef logic signed [StrideWidth-1:0] stride_t;

  // Loads go out on AR, stores on AW
  function automatic logic is_load_op(mem_op_e op);
    return op inside {VLE, VLSE};
  endfunction

  // Unit-stride accesses map onto one INCR burst
  function automatic logic is_unit_stride(mem_op_e op);
    return op inside {VLE, VSE};
  endfunction

endpackage

// File: vaddr_axi_pkg.sv
// Vector address generator AXI package
// Bus geometry, burst constants and the load/store queue entry

package vaddr_axi_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////

  // Address bus width, in bits
  localparam int unsigned AxiAddrWidth   = 32;
  // Data bus width, in bits
  localparam int unsigned AxiDataWidth   = 64;
  // Bytes carried by one full beat
  localparam int unsigned AxiStrbBytes   = AxiDataWidth / 8;
  // Address bits below the bus word, also the full-bus beat size
  localparam int unsigned AxiOffsetWidth = $clog2(AxiStrbBytes);

  // Field widths on AR/AW
  localparam int unsigned AxiSizeWidth   = 3;
  localparam int unsigned AxiLenWidth    = 8;
  localparam int unsigned AxiBurstWidth  = 2;
  localparam int unsigned AxiCacheWidth  = 4;

  // Fixed burst and cache attributes
  localparam logic [AxiBurstWidth-1:0] BurstIncr       = 2'b01;
  localparam logic [AxiCacheWidth-1:0] CacheModifiable = 4'b0010;

  ////////////////////////////////////////
  // Field types
  ////////////////////////////////////////

  typedef logic [AxiAddrWidth-1:0]  axi_addr_t;
  typedef logic [AxiLenWidth-1:0]   axi_len_t;
  typedef logic [AxiSizeWidth-1:0]  axi_size_t;
  typedef logic [AxiBurstWidth-1:0] axi_burst_t;
  typedef logic [AxiCacheWidth-1:0] axi_cache_t;

  // One issued request as seen by the load/store units
  typedef struct packed {
    axi_addr_t addr;
    axi_len_t  len;
    axi_size_t size;
    logic      is_load;
  } lsu_req_t;

endpackage
